// ==== disp_timing_pkg.sv ====
package disp_timing_pkg;

    // Pixel position on either axis
    // Also wide enough for the raw sync counters
    typedef logic [9:0] pos_t;

    // Linear tile address
    // Row times 60 plus column, 0 to 2039
    typedef logic [10:0] tile_addr_t;

endpackage

// ==== flist.f ====
+incdir+.
disp_timing_pkg.sv
pixel_pkg.sv
video_position_sync.sv
tile_frame_store.sv
palette_lut.sv
lcd_output_stage.sv
lcd_display_top.sv
tb_lcd_display.sv

// ==== lcd_display_top.sv ====
`timescale 1ns/100ps

module lcd_display_top
    import disp_timing_pkg::*;
    import pixel_pkg::*;
(
    input  logic        disp_clk,
    input  logic        rst,
    input  logic        en,
    input  color_mode_e color_mode,
    input  logic        tile_wr,       // Host tile writes
    input  tile_addr_t  tile_wr_addr,
    input  pixel_word_u tile_wr_data,
    input  logic        pal_wr,        // Host palette writes
    input  logic [7:0]  pal_wr_index,
    input  rgb565_t     pal_wr_color,
    output logic        disp_de,       // Panel pins
    output logic        disp_hsync,
    output logic        disp_vsync,
    output logic [4:0]  disp_r,
    output logic [5:0]  disp_g,
    output logic [4:0]  disp_b,
    output logic        v_blank        // Undelayed, for the host
);

    pos_t        h_pos;
    pos_t        v_pos;
    logic        valid_draw;
    logic        raw_hsync;
    logic        raw_vsync;
    pixel_word_u tile_word;    // Stage 1
    rgb565_t     pixel_color;  // Stage 2

    video_position_sync u_position_sync (
        .disp_clk   (disp_clk),
        .rst        (rst),
        .en         (en),
        .valid_draw (valid_draw),
        .v_blank    (v_blank),
        .h_pos      (h_pos),
        .v_pos      (v_pos),
        .raw_hsync  (raw_hsync),
        .raw_vsync  (raw_vsync)
    );

    tile_frame_store u_frame_store (
        .disp_clk     (disp_clk),
        .tile_wr      (tile_wr),
        .tile_wr_addr (tile_wr_addr),
        .tile_wr_data (tile_wr_data),
        .h_pos        (h_pos),
        .v_pos        (v_pos),
        .tile_word    (tile_word)
    );

    palette_lut u_palette (
        .disp_clk     (disp_clk),
        .pal_wr       (pal_wr),
        .pal_wr_index (pal_wr_index),
        .pal_wr_color (pal_wr_color),
        .tile_word    (tile_word),
        .color_mode   (color_mode),
        .pixel_color  (pixel_color)
    );

    lcd_output_stage u_output_stage (
        .disp_clk    (disp_clk),
        .rst         (rst),
        .valid_draw  (valid_draw),
        .raw_hsync   (raw_hsync),
        .raw_vsync   (raw_vsync),
        .pixel_color (pixel_color),
        .disp_de     (disp_de),
        .disp_hsync  (disp_hsync),
        .disp_vsync  (disp_vsync),
        .disp_r      (disp_r),
        .disp_g      (disp_g),
        .disp_b      (disp_b)
    );

endmodule

// ==== lcd_macros.svh ====
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// Visible area of the panel
`define LCD_H_PIXELS 480
`define LCD_V_PIXELS 272

// Horizontal timing in clock cycles
`define LCD_H_FRONT_PORCH 2
`define LCD_H_BACK_PORCH 2
`define LCD_H_LOW_WIDTH 41

// Vertical timing in lines
`define LCD_V_FRONT_PORCH 2
`define LCD_V_BACK_PORCH 2
`define LCD_V_LOW_WIDTH 10

// 8 by 8 pixel tiles
`define LCD_TILE_SHIFT 3
`define LCD_TILE_COLS 60
`define LCD_TILE_ROWS 34
`define LCD_TILE_WORDS 2040

`define LCD_PALETTE_DEPTH 256

// Frame store read plus palette lookup
`define LCD_PIPE_DELAY 2

`endif

// ==== lcd_output_stage.sv ====
`timescale 1ns/100ps
`include "lcd_macros.svh"

module lcd_output_stage
    import pixel_pkg::*;
(
    input  logic       disp_clk,
    input  logic       rst,
    input  logic       valid_draw,   // Raw enable from position sync
    input  logic       raw_hsync,
    input  logic       raw_vsync,
    input  rgb565_t    pixel_color,  // Already LCD_PIPE_DELAY cycles late
    output logic       disp_de,
    output logic       disp_hsync,
    output logic       disp_vsync,
    output logic [4:0] disp_r,
    output logic [5:0] disp_g,
    output logic [4:0] disp_b
);

    localparam int LAST = `LCD_PIPE_DELAY - 1;

    // Bit 2 enable, bit 1 hsync, bit 0 vsync
    logic [2:0] ctrl_pipe [0:LAST];
    logic       de_dly;

    always_ff @(posedge disp_clk) begin
        if (rst) begin
            for (int i = 0; i <= LAST; i++) begin
                ctrl_pipe[i] <= 3'b000;
            end
        end else begin
            ctrl_pipe[0] <= {valid_draw, raw_hsync, raw_vsync};
            for (int i = 1; i <= LAST; i++) begin
                ctrl_pipe[i] <= ctrl_pipe[i-1];  // Match the store and palette
            end
        end
    end

    assign de_dly = ctrl_pipe[LAST][2];

    // Pin register with color blanked outside the window
    always_ff @(posedge disp_clk) begin
        if (rst) begin
            disp_de    <= 1'b0;
            disp_hsync <= 1'b0;
            disp_vsync <= 1'b0;
            disp_r     <= '0;
            disp_g     <= '0;
            disp_b     <= '0;
        end else begin
            disp_de    <= de_dly;
            disp_hsync <= ctrl_pipe[LAST][1];
            disp_vsync <= ctrl_pipe[LAST][0];
            disp_r     <= de_dly ? pixel_color.red   : 5'd0;
            disp_g     <= de_dly ? pixel_color.green : 6'd0;
            disp_b     <= de_dly ? pixel_color.blue  : 5'd0;
        end
    end

    // Porches and vertical blank stay black on the pins
    assert property (@(posedge disp_clk) disable iff (rst)
        !disp_de |-> (disp_r == 5'd0) && (disp_g == 6'd0) && (disp_b == 5'd0))
        else $error("color on the panel pins while disp_de is low");

endmodule

// ==== palette_lut.sv ====
`timescale 1ns/100ps
`include "lcd_macros.svh"

module palette_lut
    import pixel_pkg::*;
(
    input  logic        disp_clk,
    input  logic        pal_wr,        // Host palette strobe
    input  logic [7:0]  pal_wr_index,
    input  rgb565_t     pal_wr_color,
    input  pixel_word_u tile_word,     // From the frame store
    input  color_mode_e color_mode,    // Level, may change between frames
    output rgb565_t     pixel_color    // One cycle after tile_word
);

    // Loaded by the host before palette mode is used
    rgb565_t pal_mem [0:`LCD_PALETTE_DEPTH-1];

    rgb565_t pal_color;   // Entry named by the tile word
    rgb565_t dec_color;   // Decoded before the register

    always_ff @(posedge disp_clk) begin
        if (pal_wr) begin
            pal_mem[pal_wr_index] <= pal_wr_color;
        end
    end

    // Low byte of the tile word selects the entry
    assign pal_color = pal_mem[tile_word.pal.pal_index];

    // Same word read through either view of the union
    always_comb begin
        if (color_mode == COLOR_PALETTE) begin
            dec_color = pal_color;
        end else begin
            dec_color = tile_word.rgb;  // Direct RGB565
        end
    end

    always_ff @(posedge disp_clk) begin
        pixel_color <= dec_color;
    end

endmodule

// ==== pixel_pkg.sv ====
package pixel_pkg;

    // Panel color word
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Tile word seen as a palette reference
    typedef struct packed {
        logic [7:0] reserved;  // Ignored in palette mode
        logic [7:0] pal_index; // Entry in the 256 color palette
    } pal_ref_t;

    // One stored tile word, read either way
    typedef union packed {
        rgb565_t  rgb;  // Direct mode view
        pal_ref_t pal;  // Palette mode view
    } pixel_word_u;

    // Selects how tile words are decoded
    typedef enum logic {
        COLOR_DIRECT  = 1'b0,
        COLOR_PALETTE = 1'b1
    } color_mode_e;

endpackage

// ==== tb_lcd_display.sv ====
`timescale 1ns/100ps
`include "lcd_macros.svh"

module tb_lcd_display
    import disp_timing_pkg::*;
    import pixel_pkg::*;
();

    localparam int H_LOW    = `LCD_H_LOW_WIDTH;
    localparam int H_PERIOD = H_LOW + `LCD_H_FRONT_PORCH + `LCD_H_PIXELS + `LCD_H_BACK_PORCH;
    localparam int V_LOW    = `LCD_V_LOW_WIDTH;
    localparam int V_PERIOD = V_LOW + `LCD_V_FRONT_PORCH + `LCD_V_PIXELS + `LCD_V_BACK_PORCH;
    localparam int FRAME_CYCLES   = H_PERIOD * V_PERIOD;  // 150150
    localparam int NUM_CASES      = 11;
    localparam int RESET_CYCLES   = 5;
    localparam int CHECKED_FRAMES = 3;
    localparam int WRITE_CYCLES   = RESET_CYCLES + `LCD_TILE_WORDS + `LCD_PALETTE_DEPTH
                                  + 2 * NUM_CASES;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + WRITE_CYCLES;
    localparam int VB_TAP         = `LCD_PIPE_DELAY;  // v_blank leads the pins by VB_TAP + 1

    logic        disp_clk = 1'b0;
    logic        rst;
    logic        en;
    color_mode_e color_mode;
    logic        tile_wr;
    tile_addr_t  tile_wr_addr;
    pixel_word_u tile_wr_data;
    logic        pal_wr;
    logic [7:0]  pal_wr_index;
    rgb565_t     pal_wr_color;
    logic        disp_de;
    logic        disp_hsync;
    logic        disp_vsync;
    logic [4:0]  disp_r;
    logic [5:0]  disp_g;
    logic [4:0]  disp_b;
    logic        v_blank;

    // Case table, one row per index
    string       case_name  [NUM_CASES];
    color_mode_e case_mode  [NUM_CASES];
    int          case_tx    [NUM_CASES];
    int          case_ty    [NUM_CASES];
    logic [15:0] case_word  [NUM_CASES];
    logic [15:0] case_pal   [NUM_CASES];  // Palette entry color, palette rows only
    logic [15:0] case_exp   [NUM_CASES];  // Pixel color in the row's own mode
    int          case_phase [NUM_CASES];  // 0 before enable, 1 after frame 2

    logic [15:0] shadow_tile [`LCD_TILE_WORDS];
    logic [15:0] shadow_pal  [`LCD_PALETTE_DEPTH];
    int          tile_case   [`LCD_TILE_WORDS];  // Owning table row or -1

    integer seed = 32'h7184;
    int   error_count = 0;
    int   check_count = 0;
    int   cycle_count = 0;
    int   timeout_count = 0;
    int   en_cycle = 0;
    int   hfall_cycle = 0;
    int   vfall_cycle = 0;
    int   pixel_run = 0;   // x within the current line
    int   line_count = 0;  // y within the current frame
    int   frames_done = 0;
    logic en_seen = 1'b0;
    logic hfall_seen = 1'b0;
    logic vfall_seen = 1'b0;
    logic frame_open = 1'b0;
    logic idle_check = 1'b0;
    logic monitor_on = 1'b0;
    logic prev_de = 1'b0;
    logic prev_hsync = 1'b0;
    logic prev_vsync = 1'b0;
    logic [VB_TAP:0] vb_hist = '0;  // Recent v_blank samples, newest in bit 0

    lcd_display_top u_lcd_display_top (
        .disp_clk     (disp_clk),
        .rst          (rst),
        .en           (en),
        .color_mode   (color_mode),
        .tile_wr      (tile_wr),
        .tile_wr_addr (tile_wr_addr),
        .tile_wr_data (tile_wr_data),
        .pal_wr       (pal_wr),
        .pal_wr_index (pal_wr_index),
        .pal_wr_color (pal_wr_color),
        .disp_de      (disp_de),
        .disp_hsync   (disp_hsync),
        .disp_vsync   (disp_vsync),
        .disp_r       (disp_r),
        .disp_g       (disp_g),
        .disp_b       (disp_b),
        .v_blank      (v_blank)
    );

    always #2 disp_clk = ~disp_clk;  // 4 ns period

    task automatic next_cycle();
        @(posedge disp_clk);
        #0.5;  // Inputs change just after the edge
    endtask

    task automatic set_case(input int idx, input string name, input color_mode_e mode,
                            input int tx, input int ty, input logic [15:0] word,
                            input logic [15:0] pal, input logic [15:0] exp_color,
                            input int phase);
        case_name[idx]  = name;
        case_mode[idx]  = mode;
        case_tx[idx]    = tx;
        case_ty[idx]    = ty;
        case_word[idx]  = word;
        case_pal[idx]   = pal;
        case_exp[idx]   = exp_color;
        case_phase[idx] = phase;
    endtask

    task automatic load_case_table();
        set_case(0,  "direct_corner_tl", COLOR_DIRECT,  0,  0,  16'hF800, 16'h0, 16'hF800, 0);
        set_case(1,  "direct_black",     COLOR_DIRECT,  1,  0,  16'h0000, 16'h0, 16'h0000, 0);
        set_case(2,  "direct_corner_br", COLOR_DIRECT,  59, 33, 16'h07E0, 16'h0, 16'h07E0, 0);
        set_case(3,  "direct_mid",       COLOR_DIRECT,  30, 17, 16'h001F, 16'h0, 16'h001F, 0);
        set_case(4,  "direct_white",     COLOR_DIRECT,  31, 17, 16'hFFFF, 16'h0, 16'hFFFF, 0);
        // Two tiles share entry 0x5A
        set_case(5,  "pal_shared_a",     COLOR_PALETTE, 10, 5,  16'h335A, 16'hABCD, 16'hABCD, 0);
        set_case(6,  "pal_shared_b",     COLOR_PALETTE, 11, 5,  16'hC75A, 16'hABCD, 16'hABCD, 0);
        set_case(7,  "pal_edge_left",    COLOR_PALETTE, 0,  20, 16'h0003, 16'h1234, 16'h1234, 0);
        set_case(8,  "pal_edge_right",   COLOR_PALETTE, 59, 0,  16'h80FF, 16'h8421, 16'h8421, 0);
        // Entry 0x5A rewritten, both tiles follow
        set_case(9,  "pal_rewrite_a",    COLOR_PALETTE, 10, 5,  16'h335A, 16'h5EED, 16'h5EED, 1);
        set_case(10, "pal_rewrite_b",    COLOR_PALETTE, 11, 5,  16'hC75A, 16'h5EED, 16'h5EED, 1);
    endtask

    task automatic write_tile(input int addr, input logic [15:0] word);
        tile_wr      = 1'b1;
        tile_wr_addr = tile_addr_t'(addr);
        tile_wr_data = word;
        next_cycle();
        tile_wr      = 1'b0;
        shadow_tile[addr] = word;
    endtask

    task automatic write_palette(input logic [7:0] index, input logic [15:0] color);
        pal_wr       = 1'b1;
        pal_wr_index = index;
        pal_wr_color = color;
        next_cycle();
        pal_wr       = 1'b0;
        shadow_pal[index] = color;
    endtask

    task automatic apply_cases(input int phase);
        int addr;
        for (int i = 0; i < NUM_CASES; i++) begin
            if (case_phase[i] == phase) begin
                addr = case_ty[i] * `LCD_TILE_COLS + case_tx[i];
                write_tile(addr, case_word[i]);
                tile_case[addr] = i;
                if (case_mode[i] == COLOR_PALETTE) begin
                    write_palette(case_word[i][7:0], case_pal[i]);
                end
            end
        end
    endtask

    task automatic wait_frames(input int count);
        while (frames_done < count) begin
            next_cycle();
        end
    endtask

    task automatic report_error(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        error_count++;
        $display("** Error %s: expected %0d actual %0d", name, exp_val, act_val);
    endtask

    task automatic check_pixel(input int px, input int py);
        int          tile;
        int          row;
        logic [15:0] exp_color;
        logic [15:0] act_color;
        string       name;
        tile = (py >> `LCD_TILE_SHIFT) * `LCD_TILE_COLS + (px >> `LCD_TILE_SHIFT);
        row  = tile_case[tile];
        name = "background";
        if (row >= 0) begin
            name = case_name[row];
        end
        if (row >= 0 && case_mode[row] == color_mode) begin
            exp_color = case_exp[row];
        end else if (color_mode == COLOR_DIRECT) begin
            exp_color = shadow_tile[tile];  // Word shown as RGB565
        end else begin
            exp_color = shadow_pal[shadow_tile[tile][7:0]];
        end
        act_color = {disp_r, disp_g, disp_b};
        check_count++;
        if (act_color !== exp_color) begin
            error_count++;
            $display("** Error %s: pixel (%0d,%0d) expected %h actual %h",
                     name, px, py, exp_color, act_color);
        end
    endtask

    // Panel monitor, sampled mid-cycle
    always @(negedge disp_clk) begin
        cycle_count++;
        if (en && !en_seen) begin
            en_seen  = 1'b1;
            en_cycle = cycle_count;
        end
        if (idle_check && {disp_de, disp_hsync, disp_vsync, disp_r, disp_g, disp_b} !== '0) begin
            report_error("idle_pins", 0, {disp_de, disp_hsync, disp_vsync, disp_r, disp_g, disp_b});
        end
        if (monitor_on) begin
            if (disp_de !== 1'b1 && {disp_r, disp_g, disp_b} !== 16'h0000) begin
                report_error("blanking", 0, {disp_r, disp_g, disp_b});
            end
            if (!prev_hsync && disp_hsync && hfall_seen && cycle_count - hfall_cycle != H_LOW) begin
                report_error("hsync_low", H_LOW, cycle_count - hfall_cycle);
            end
            if (prev_hsync && !disp_hsync) begin
                if (hfall_seen && cycle_count - hfall_cycle != H_PERIOD) begin
                    report_error("hsync_period", H_PERIOD, cycle_count - hfall_cycle);
                end
                hfall_seen  = 1'b1;
                hfall_cycle = cycle_count;
            end
            if (!prev_vsync && disp_vsync) begin  // Active lines follow
                if (vfall_seen && cycle_count - vfall_cycle != V_LOW * H_PERIOD) begin
                    report_error("vsync_low", V_LOW * H_PERIOD, cycle_count - vfall_cycle);
                end
                // First pulse after enable, counted from the first enabled edge
                if (!vfall_seen && (cycle_count - en_cycle < V_LOW * H_PERIOD ||
                    cycle_count - en_cycle > V_LOW * H_PERIOD + `LCD_PIPE_DELAY + 2)) begin
                    report_error("enable_to_vsync", V_LOW * H_PERIOD, cycle_count - en_cycle);
                end
                frame_open = 1'b1;
                line_count = 0;
            end
            if (prev_vsync && !disp_vsync) begin
                if (vfall_seen && cycle_count - vfall_cycle != FRAME_CYCLES) begin
                    report_error("vsync_period", FRAME_CYCLES, cycle_count - vfall_cycle);
                end
                if (frame_open && line_count != `LCD_V_PIXELS) begin
                    report_error("frame_lines", `LCD_V_PIXELS, line_count);
                end
                frames_done = frames_done + frame_open;
                frame_open  = 1'b0;
                vfall_seen  = 1'b1;
                vfall_cycle = cycle_count;
            end
            // Undelayed v_blank, lined up with the pins it leads
            if (disp_de === 1'b1 && vb_hist[VB_TAP] !== 1'b0) begin
                report_error("v_blank_active", 0, vb_hist[VB_TAP]);
            end
            if (vfall_seen && disp_vsync === 1'b0 && vb_hist[VB_TAP] !== 1'b1) begin
                report_error("v_blank_sync", 1, vb_hist[VB_TAP]);
            end
            if (disp_de === 1'b1) begin
                if (!frame_open) begin
                    error_count++;
                    $display("disp_de high during the vsync pulse or before the first frame");
                end
                if (!prev_de) begin
                    pixel_run = 0;
                end
                if (frame_open && pixel_run < `LCD_H_PIXELS && line_count < `LCD_V_PIXELS) begin
                    check_pixel(pixel_run, line_count);
                end
                pixel_run++;
            end else if (prev_de) begin
                if (pixel_run != `LCD_H_PIXELS) begin
                    report_error("line_width", `LCD_H_PIXELS, pixel_run);
                end
                line_count++;
            end
        end
        prev_de    = disp_de;
        prev_hsync = disp_hsync;
        prev_vsync = disp_vsync;
        vb_hist    = {vb_hist[VB_TAP-1:0], v_blank};
    end

    initial begin
        rst          = 1'b1;
        en           = 1'b0;
        color_mode   = COLOR_DIRECT;
        tile_wr      = 1'b0;
        tile_wr_addr = '0;
        tile_wr_data = '0;
        pal_wr       = 1'b0;
        pal_wr_index = '0;
        pal_wr_color = '0;
        load_case_table();
        for (int i = 0; i < `LCD_TILE_WORDS; i++) begin
            tile_case[i] = -1;
        end
        repeat (RESET_CYCLES) begin
            next_cycle();
            idle_check = 1'b1;  // Pins defined from the first reset edge on
        end
        rst        = 1'b0;
        monitor_on = 1'b1;
        // Background fill while the panel is still disabled
        for (int i = 0; i < `LCD_TILE_WORDS; i++) begin
            write_tile(i, 16'($random(seed)));
        end
        for (int i = 0; i < `LCD_PALETTE_DEPTH; i++) begin
            write_palette(8'(i), 16'($random(seed)));
        end
        apply_cases(0);
        idle_check = 1'b0;
        en         = 1'b1;
        wait_frames(1);
        color_mode = COLOR_PALETTE;  // Frames 2 and 3
        wait_frames(2);
        apply_cases(1);              // Lands in vertical blank before frame 3
        wait_frames(3);
        next_cycle();
        if (check_count != CHECKED_FRAMES * `LCD_H_PIXELS * `LCD_V_PIXELS) begin
            report_error("pixel_count", CHECKED_FRAMES * `LCD_H_PIXELS * `LCD_V_PIXELS,
                         check_count);
        end
        $display("pixel checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Run limit from the frame length and the write phase
    initial begin
        while (timeout_count < TIMEOUT_CYCLES) begin
            @(posedge disp_clk);
            timeout_count++;
        end
        $display("Run stopped after %0d cycles with only %0d of %0d frames finished",
                 timeout_count, frames_done, CHECKED_FRAMES);
        $display("pixel checks %0d, errors %0d", check_count, error_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tile_frame_store.sv ====
`timescale 1ns/100ps
`include "lcd_macros.svh"

module tile_frame_store
    import disp_timing_pkg::*;
    import pixel_pkg::*;
(
    input  logic        disp_clk,
    input  logic        tile_wr,       // One word per strobe cycle
    input  tile_addr_t  tile_wr_addr,
    input  pixel_word_u tile_wr_data,
    input  pos_t        h_pos,
    input  pos_t        v_pos,
    output pixel_word_u tile_word      // One cycle after the position
);

    localparam int TILE_IDX_W = $bits(pos_t) - `LCD_TILE_SHIFT;

    pixel_word_u store_mem [0:`LCD_TILE_WORDS-1];  // One word per tile

    logic [TILE_IDX_W-1:0] tile_col_raw;
    logic [TILE_IDX_W-1:0] tile_row_raw;
    logic [5:0]            tile_col;   // 0 to 59
    logic [5:0]            tile_row;   // 0 to 33
    tile_addr_t            row_ext;
    tile_addr_t            row_base;
    tile_addr_t            rd_addr;

    // Drop the pixel bits within a tile
    assign tile_col_raw = h_pos[$bits(pos_t)-1:`LCD_TILE_SHIFT];
    assign tile_row_raw = v_pos[$bits(pos_t)-1:`LCD_TILE_SHIFT];

    // Porch and blank positions land on the last tile
    assign tile_col = (tile_col_raw < `LCD_TILE_COLS) ? tile_col_raw[5:0]
                                                      : 6'(`LCD_TILE_COLS - 1);
    assign tile_row = (tile_row_raw < `LCD_TILE_ROWS) ? tile_row_raw[5:0]
                                                      : 6'(`LCD_TILE_ROWS - 1);

    // Row times 60 as 32 + 16 + 8 + 4
    assign row_ext  = {5'd0, tile_row};
    assign row_base = (row_ext << 5) + (row_ext << 4) + (row_ext << 3) + (row_ext << 2);
    assign rd_addr  = row_base + {5'd0, tile_col};

    always_ff @(posedge disp_clk) begin
        if (tile_wr) begin
            store_mem[tile_wr_addr] <= tile_wr_data;
        end
        tile_word <= store_mem[rd_addr];  // Sees writes from earlier cycles
    end

    // Host must stay inside the 60 by 34 grid
    assert property (@(posedge disp_clk)
        tile_wr |-> tile_wr_addr < `LCD_TILE_WORDS)
        else $error("tile write address %0d beyond the store", tile_wr_addr);

endmodule

// ==== video_position_sync.sv ====
`timescale 1ns/100ps
`include "lcd_macros.svh"

module video_position_sync
    import disp_timing_pkg::*;
(
    input  logic disp_clk,
    input  logic rst,
    input  logic en,          // Low holds everything cleared
    output logic valid_draw,  // Inside the 480 by 272 window
    output logic v_blank,
    output pos_t h_pos,
    output pos_t v_pos,
    output logic raw_hsync,   // Before output alignment
    output logic raw_vsync
);

    // Draw window opens 2 counts early in x and 1 line early in y
    localparam pos_t H_MIN_VALID = `LCD_H_LOW_WIDTH + `LCD_H_FRONT_PORCH - 2;
    localparam pos_t H_MAX_VALID = H_MIN_VALID + `LCD_H_PIXELS;
    localparam pos_t H_MAX_COUNT = `LCD_H_LOW_WIDTH + `LCD_H_FRONT_PORCH
                                 + `LCD_H_PIXELS + `LCD_H_BACK_PORCH - 1; // 525 per line

    localparam pos_t V_MIN_VALID = `LCD_V_LOW_WIDTH + `LCD_V_FRONT_PORCH - 1;
    localparam pos_t V_MAX_VALID = V_MIN_VALID + `LCD_V_PIXELS;
    localparam pos_t V_MAX_COUNT = `LCD_V_LOW_WIDTH + `LCD_V_FRONT_PORCH
                                 + `LCD_V_PIXELS + `LCD_V_BACK_PORCH - 1; // 286 per frame

    pos_t h_count;       // Cycle within the line
    pos_t v_count;       // Line within the frame
    pos_t next_h_count;
    pos_t next_v_count;
    logic h_valid;
    logic v_valid;
    logic next_hsync;
    logic next_vsync;

    assign h_valid = (h_count >= H_MIN_VALID) && (h_count < H_MAX_VALID);
    assign v_valid = (v_count >= V_MIN_VALID) && (v_count < V_MAX_VALID);

    // Low pulses open each line and frame
    assign next_hsync = (h_count >= `LCD_H_LOW_WIDTH);
    assign next_vsync = (v_count >= `LCD_V_LOW_WIDTH);

    always_comb begin
        next_h_count = h_count + 10'd1;
        next_v_count = v_count;
        if (h_count == H_MAX_COUNT) begin  // End of line
            next_h_count = '0;
            if (v_count == V_MAX_COUNT) begin
                next_v_count = '0;         // End of frame
            end else begin
                next_v_count = v_count + 10'd1;
            end
        end
    end

    always_ff @(posedge disp_clk) begin
        if (rst || !en) begin  // Disabled looks the same as reset
            valid_draw <= 1'b0;
            v_blank    <= 1'b0;
            h_count    <= '0;
            v_count    <= '0;
            h_pos      <= '0;
            v_pos      <= '0;
            raw_hsync  <= 1'b0;
            raw_vsync  <= 1'b0;
        end else begin
            valid_draw <= h_valid && v_valid;
            v_blank    <= !v_valid;
            h_count    <= next_h_count;
            v_count    <= next_v_count;
            h_pos      <= h_count - H_MIN_VALID;  // Wraps outside the window
            v_pos      <= v_count - V_MIN_VALID;
            raw_hsync  <= next_hsync;
            raw_vsync  <= next_vsync;
        end
    end

    // Registered sync low only for counts inside the pulse
    assert property (@(posedge disp_clk) disable iff (rst)
        $past(en && !rst) && !raw_hsync |-> $past(h_count) < `LCD_H_LOW_WIDTH)
        else $error("raw_hsync low outside its pulse window");

    assert property (@(posedge disp_clk) disable iff (rst)
        valid_draw |-> !v_blank)
        else $error("valid_draw high during vertical blank");

endmodule
